// ==== csr_file.f ====
common/csr_pkg.sv
irq/irq_ctrl.sv
trap/trap_ctrl.sv
source/csr_read_mux.sv
source/csr_file.sv
sim/csr_file_assert.sv
sim/tb_csr_file.sv

// ==== sim/tb_csr_file.sv ====
// Table-driven testbench for the trap and privilege CSR block
// Rows are driven on the falling edge and checked before the next rise
`default_nettype none

module tb_csr_file;
    import csr_pkg::*;

    localparam int RST_CYCLES = 8;
    localparam int MAX_ROWS   = 64;
    // Don't-care bits 0 rdata, 1 valid, 2 priv, 3 to_s, 4 vector, 5 return pc, 6 pend, 7 cause
    localparam logic [7:0] DC_TRAP  = 8'b0011_1000;
    localparam logic [7:0] DC_RPC   = 8'b0010_0000;
    localparam logic [7:0] DC_CAUSE = 8'b1000_0000;

    typedef struct packed {
        logic [2:0]  test;
        logic        wr;
        logic [11:0] waddr;
        logic [31:0] wdata;
        logic        trap;
        logic [31:0] cause, pc, tval;
        logic        mret, sret;
        logic [2:0]  irq;     // External, timer, software
        logic [11:0] raddr;
        logic [31:0] rdata;
        logic        valid;
        logic [1:0]  priv;
        logic        tos;
        logic [31:0] vec, rpc;
        logic        pend;
        logic [31:0] icause;
        logic [7:0]  dc;
    } row_t;

    logic            clk, rst, csr_write, csr_addr_valid;
    csr_addr_e       csr_addr, csr_waddr;
    logic [XLEN-1:0] csr_wdata, csr_rdata, trap_cause, trap_pc, trap_val;
    logic            trap_taken, mret_taken, sret_taken;
    logic            timer_irq, external_irq, software_irq;
    priv_e           priv_level;
    logic            interrupt_pending, trap_to_s_mode;
    logic [XLEN-1:0] interrupt_cause, trap_vector, trap_return_pc;

    row_t            tbl [MAX_ROWS];
    row_t            stg, r;             // Row being built, row being applied
    int              n_rows = 0;
    int              cur_test, errors, test_errs, failed_tests;
    bit              setup_done = 1'b0;
    integer          seed;
    logic [XLEN-1:0] scratch, pc1, pc2, pc3, pc4, mtvec_exp, stvec_exp;
    string           test_name [1:6];

    csr_file dut_i (.*);

    always #5 clk = ~clk;

    task automatic write_stim(input logic [11:0] addr, input logic [31:0] data);
        stg.wr    = 1'b1;
        stg.waddr = addr;
        stg.wdata = data;
    endtask

    // Trap inputs plus the expected delegation and vector
    task automatic trap_stim(input logic [31:0] cause, input logic [31:0] pc,
                             input logic [31:0] tval, input logic tos, input logic [31:0] vec);
        stg.trap  = 1'b1;
        stg.cause = cause;
        stg.pc    = pc;
        stg.tval  = tval;
        stg.tos   = tos;
        stg.vec   = vec;
    endtask

    task automatic push_row(input logic [11:0] raddr, input logic [31:0] rdata,
                            input logic valid, input logic [1:0] priv, input logic pend,
                            input logic [31:0] icause, input logic [7:0] dc);
        stg.test    = cur_test[2:0];
        stg.raddr   = raddr;
        stg.rdata   = rdata;
        stg.valid   = valid;
        stg.priv    = priv;
        stg.pend    = pend;
        stg.icause  = icause;
        stg.dc      = dc;
        tbl[n_rows] = stg;
        n_rows++;
        stg = '0;  // Next row starts idle
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
        errors++;
        test_errs++;
    endtask

    // ========================================
    // Stimulus table and run
    // ========================================
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        csr_write = 1'b0;
        csr_addr = MSTATUS;
        csr_waddr = MSTATUS;
        csr_wdata = '0;
        trap_taken = 1'b0;
        trap_cause = '0;
        trap_pc = '0;
        trap_val = '0;
        mret_taken = 1'b0;
        sret_taken = 1'b0;
        {external_irq, timer_irq, software_irq} = 3'b000;
        errors = 0;
        test_errs = 0;
        failed_tests = 0;
        test_name[1] = "reset values";
        test_name[2] = "writes and masks";
        test_name[3] = "trap to M and MRET";
        test_name[4] = "delegation and SRET";
        test_name[5] = "interrupts";
        test_name[6] = "write and trap together";

        seed      = 32'hc54b4f7d;
        scratch   = $random(seed);
        pc1       = $random(seed);
        pc2       = $random(seed);
        pc3       = $random(seed);
        pc4       = $random(seed);
        mtvec_exp = 32'h8000_0103 & ~32'h3;  // Base aligned to 4
        stvec_exp = 32'h4000_0207 & ~32'h3;
        stg       = '0;

        // Each row reads state before its own write or trap lands
        cur_test = 1;
        push_row(MSTATUS, 32'h0000_1800, 1, PRIV_M, 0, 0, DC_RPC);  // MPP = M
        push_row(MISA, 32'h4004_1101, 1, PRIV_M, 0, 0, DC_RPC);     // RV32 A I M S
        push_row(12'hC00, 0, 0, PRIV_M, 0, 0, DC_RPC);

        cur_test = 2;
        write_stim(MTVEC, 32'h8000_0103);
        push_row(MTVEC, 0, 1, PRIV_M, 0, 0, DC_TRAP);
        write_stim(STVEC, 32'h4000_0207);
        push_row(MTVEC, mtvec_exp, 1, PRIV_M, 0, 0, DC_TRAP);
        write_stim(MEPC, 32'h0000_1235);
        push_row(STVEC, stvec_exp, 1, PRIV_M, 0, 0, DC_TRAP);
        write_stim(MEDELEG, '1);
        push_row(MEPC, 32'h0000_1234, 1, PRIV_M, 0, 0, DC_TRAP);     // Bit 0 cleared
        write_stim(MIDELEG, '1);
        push_row(MEDELEG, 32'h0000_B3FF, 1, PRIV_M, 0, 0, DC_TRAP);
        write_stim(MIE, '1);
        push_row(MIDELEG, 32'h0000_0222, 1, PRIV_M, 0, 0, DC_TRAP);  // S interrupts only
        write_stim(SIE, 32'h0);
        push_row(MIE, 32'h0000_0AAA, 1, PRIV_M, 0, 0, DC_TRAP);
        write_stim(MSCRATCH, scratch);
        push_row(MIE, 32'h0000_0888, 1, PRIV_M, 0, 0, DC_TRAP);      // Bits 9 5 1 cleared
        push_row(MSCRATCH, scratch, 1, PRIV_M, 0, 0, DC_TRAP);

        cur_test = 3;
        write_stim(MSTATUS, 32'h0000_0008);  // MIE set with MPP = U
        push_row(MSTATUS, 32'h0000_1800, 1, PRIV_M, 0, 0, DC_TRAP);
        trap_stim(2, pc1, 32'hDEAD_BEEF, 0, mtvec_exp);  // Illegal instruction
        push_row(MSTATUS, 32'h0000_0008, 1, PRIV_M, 0, 0, DC_RPC);
        stg.mret = 1'b1;
        push_row(MSTATUS, 32'h0000_1880, 1, PRIV_M, 0, 0, DC_TRAP);  // MIE 0, MPIE 1, MPP M
        stg.mret = 1'b1;
        push_row(MEPC, pc1, 1, PRIV_M, 0, 0, DC_TRAP);  // First MRET went back to M
        push_row(MSTATUS, 32'h0000_0088, 1, PRIV_U, 0, 0, DC_TRAP);
        push_row(MCAUSE, 32'h2, 1, PRIV_U, 0, 0, DC_TRAP);
        push_row(MTVAL, 32'hDEAD_BEEF, 1, PRIV_U, 0, 0, DC_TRAP);

        cur_test = 4;
        trap_stim(8, pc2, 0, 1, stvec_exp);  // Delegated ecall from U
        push_row(SSTATUS, 0, 1, PRIV_U, 0, 0, DC_RPC);
        push_row(SCAUSE, 8, 1, PRIV_S, 0, 0, DC_TRAP);
        push_row(SSTATUS, 0, 1, PRIV_S, 0, 0, DC_TRAP);  // SPP 0
        stg.sret = 1'b1;
        stg.rpc  = pc2;
        push_row(SEPC, pc2, 1, PRIV_S, 0, 0, 8'b0001_1000);
        push_row(SSTATUS, 32'h0000_0020, 1, PRIV_U, 0, 0, DC_TRAP);  // SPIE set by SRET
        trap_stim(11, pc3, 0, 0, mtvec_exp);
        push_row(MSTATUS, 32'h0000_00A8, 1, PRIV_U, 0, 0, DC_RPC);
        trap_stim(8, pc3, 0, 0, mtvec_exp);  // Same cause from M stays in M
        push_row(MCAUSE, 11, 1, PRIV_M, 0, 0, DC_RPC);
        push_row(MCAUSE, 8, 1, PRIV_M, 0, 0, DC_TRAP);

        cur_test = 5;
        write_stim(MIE, 32'h0000_0AAA);
        stg.irq = 3'b111;
        push_row(MIP, 32'h0000_0888, 1, PRIV_M, 0, 0, DC_TRAP);  // MIE still 0
        write_stim(MSTATUS, 32'h0000_1808);
        stg.irq = 3'b111;
        push_row(MIE, 32'h0000_0AAA, 1, PRIV_M, 0, 0, DC_TRAP);
        stg.irq = 3'b111;
        push_row(MSTATUS, 32'h0000_1808, 1, PRIV_M, 1, 32'h8000_000B, DC_TRAP);
        stg.irq = 3'b011;
        push_row(MIP, 32'h0000_0088, 1, PRIV_M, 1, 32'h8000_0003, DC_TRAP);  // MSI over MTI
        write_stim(MSTATUS, 32'h0000_1800);
        stg.irq = 3'b011;
        push_row(MIP, 32'h0000_0088, 1, PRIV_M, 1, 32'h8000_0003, DC_TRAP);
        stg.irq = 3'b011;
        push_row(MSTATUS, 32'h0000_1800, 1, PRIV_M, 0, 0, DC_TRAP);
        write_stim(MIP, 32'h0000_0020);  // STIP
        push_row(SIP, 0, 1, PRIV_M, 0, 0, DC_TRAP);
        write_stim(MSTATUS, 32'h0);  // MPP = U for the MRET
        push_row(SIP, 32'h0000_0020, 1, PRIV_M, 0, 0, DC_TRAP | DC_CAUSE);
        stg.mret = 1'b1;
        push_row(MSTATUS, 0, 1, PRIV_M, 0, 0, DC_TRAP | DC_CAUSE);
        push_row(MIP, 32'h0000_0020, 1, PRIV_U, 1, 32'h8000_0005, DC_TRAP);

        cur_test = 6;
        write_stim(MSTATUS, 32'h0000_0088);  // Would set MIE and MPIE
        trap_stim(11, pc4, 0, 0, mtvec_exp);
        push_row(MSTATUS, 32'h0000_0080, 1, PRIV_U, 1, 32'h8000_0005, DC_RPC);
        push_row(MSTATUS, 0, 1, PRIV_M, 0, 0, DC_TRAP | DC_CAUSE);  // Trap fields win
        push_row(MEPC, pc4, 1, PRIV_M, 0, 0, DC_TRAP | DC_CAUSE);
        setup_done = 1'b1;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            r = tbl[i];
            @(negedge clk);
            csr_write  = r.wr;
            csr_waddr  = csr_addr_e'(r.waddr);
            csr_wdata  = r.wdata;
            trap_taken = r.trap;
            trap_cause = r.cause;
            trap_pc    = r.pc;
            trap_val   = r.tval;
            mret_taken = r.mret;
            sret_taken = r.sret;
            {external_irq, timer_irq, software_irq} = r.irq;
            csr_addr   = csr_addr_e'(r.raddr);
            #2;  // Outputs settled 3 units before the rising edge
            if (!r.dc[0] && csr_rdata !== r.rdata)
                report_mismatch("csr_rdata", r.rdata, csr_rdata);
            if (!r.dc[1] && csr_addr_valid !== r.valid)
                report_mismatch("csr_addr_valid", r.valid, csr_addr_valid);
            if (!r.dc[2] && priv_level !== r.priv)
                report_mismatch("priv_level", r.priv, priv_level);
            if (!r.dc[3] && trap_to_s_mode !== r.tos)
                report_mismatch("trap_to_s_mode", r.tos, trap_to_s_mode);
            if (!r.dc[4] && trap_vector !== r.vec)
                report_mismatch("trap_vector", r.vec, trap_vector);
            if (!r.dc[5] && trap_return_pc !== r.rpc)
                report_mismatch("trap_return_pc", r.rpc, trap_return_pc);
            if (!r.dc[6] && interrupt_pending !== r.pend)
                report_mismatch("interrupt_pending", r.pend, interrupt_pending);
            if (!r.dc[7] && interrupt_cause !== r.icause)
                report_mismatch("interrupt_cause", r.icause, interrupt_cause);
            // Last row of a test
            if (i == n_rows - 1 || tbl[i+1].test != r.test) begin
                $display("Test %0d, %s: %0d mismatches", r.test, test_name[r.test], test_errs);
                if (test_errs != 0) failed_tests++;
                test_errs = 0;
            end
        end

        @(negedge clk);
        errors += dut_i.csr_file_assert_i.fail_count;
        $display("Rows %0d, failed tests %0d, assertion failures %0d, total errors %0d",
                 n_rows, failed_tests, dut_i.csr_file_assert_i.fail_count, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // Watchdog at four times the expected run length
    initial begin
        wait (setup_done);
        #((n_rows + RST_CYCLES) * 10 * 4);
        $display("Watchdog timeout: the table did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/csr_file_assert.sv ====
// Concurrent checks on privilege, delegation and interrupt outputs of csr_file
// Bound to every csr_file instance, fail_count is read by the testbench summary
`default_nettype none

module csr_file_assert (
    input logic                      clk,
    input logic                      rst,
    input csr_pkg::priv_e            priv_level,
    input logic                      trap_taken,
    input logic                      trap_to_s_mode,
    input logic                      interrupt_pending,
    input logic [csr_pkg::XLEN-1:0]  interrupt_cause
);
    import csr_pkg::*;

    int unsigned fail_count = 0;

    // Encoding 2 is reserved
    priv_legal: assert property (@(posedge clk) disable iff (rst) priv_level != 2'b10)
        else begin
            $error("priv_level holds the reserved encoding 2");
            fail_count++;
        end

    no_s_from_m: assert property (@(posedge clk) disable iff (rst)
        (priv_level == PRIV_M) |-> !trap_to_s_mode)
        else begin
            $error("trap_to_s_mode high while in M mode");
            fail_count++;
        end

    // Interrupt causes carry bit 31
    irq_cause_flag: assert property (@(posedge clk) disable iff (rst)
        interrupt_pending |-> interrupt_cause[XLEN-1])
        else begin
            $error("interrupt_cause lacks bit 31 while interrupt_pending is high");
            fail_count++;
        end

    trap_to_m: assert property (@(posedge clk) disable iff (rst)
        (trap_taken && !trap_to_s_mode) |=> (priv_level == PRIV_M))
        else begin
            $error("undelegated trap did not enter M mode");
            fail_count++;
        end

endmodule

bind csr_file csr_file_assert csr_file_assert_i (.*);

`default_nettype wire

// ==== source/csr_file.sv ====
// Top of the trap and privilege CSR block for one M/S/U hart
// Combinational read port, single-cycle write strobe, trap and return inputs
`default_nettype none

module csr_file (
    input  logic                      clk,
    input  logic                      rst,
    // Read port
    input  csr_pkg::csr_addr_e        csr_addr,
    output logic [csr_pkg::XLEN-1:0]  csr_rdata,
    output logic                      csr_addr_valid,
    // Write port
    input  logic                      csr_write,
    input  csr_pkg::csr_addr_e        csr_waddr,
    input  logic [csr_pkg::XLEN-1:0]  csr_wdata,
    // Trap entry and return
    input  logic                      trap_taken,
    input  logic [csr_pkg::XLEN-1:0]  trap_cause,
    input  logic [csr_pkg::XLEN-1:0]  trap_pc,
    input  logic [csr_pkg::XLEN-1:0]  trap_val,
    input  logic                      mret_taken,
    input  logic                      sret_taken,
    // Interrupt lines
    input  logic                      timer_irq,
    input  logic                      external_irq,
    input  logic                      software_irq,
    // Status to the pipeline
    output csr_pkg::priv_e            priv_level,
    output logic                      interrupt_pending,
    output logic [csr_pkg::XLEN-1:0]  interrupt_cause,
    output logic [csr_pkg::XLEN-1:0]  trap_vector,
    output logic [csr_pkg::XLEN-1:0]  trap_return_pc,
    output logic                      trap_to_s_mode
);
    import csr_pkg::*;

    logic            mstatus_mie, mstatus_mpie;
    logic            mstatus_sie, mstatus_spie, mstatus_spp;
    priv_e           mstatus_mpp;
    logic [XLEN-1:0] mtvec, stvec, mscratch, sscratch;
    logic [XLEN-1:0] mepc, sepc, mcause, scause, mtval, stval;
    logic [XLEN-1:0] medeleg, mie, mideleg, mip;

    // Privilege, mstatus and trap CSRs
    trap_ctrl trap_ctrl_i (
        .clk(clk), .rst(rst),
        .csr_write(csr_write), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .trap_taken(trap_taken), .trap_cause(trap_cause),
        .trap_pc(trap_pc), .trap_val(trap_val),
        .mret_taken(mret_taken), .sret_taken(sret_taken),
        .mideleg(mideleg),
        .priv_level(priv_level),
        .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie),
        .mstatus_sie(mstatus_sie), .mstatus_spie(mstatus_spie),
        .mstatus_spp(mstatus_spp), .mstatus_mpp(mstatus_mpp),
        .mtvec(mtvec), .stvec(stvec), .mscratch(mscratch), .sscratch(sscratch),
        .mepc(mepc), .sepc(sepc), .mcause(mcause), .scause(scause),
        .mtval(mtval), .stval(stval), .medeleg(medeleg),
        .trap_vector(trap_vector), .trap_return_pc(trap_return_pc),
        .trap_to_s_mode(trap_to_s_mode)
    );

    // Interrupt enables, delegation and arbitration
    irq_ctrl irq_ctrl_i (
        .clk(clk), .rst(rst),
        .csr_write(csr_write), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .timer_irq(timer_irq), .external_irq(external_irq),
        .software_irq(software_irq),
        .priv_level(priv_level),
        .mstatus_mie(mstatus_mie), .mstatus_sie(mstatus_sie),
        .mie(mie), .mideleg(mideleg), .mip(mip),
        .interrupt_pending(interrupt_pending), .interrupt_cause(interrupt_cause)
    );

    csr_read_mux csr_read_mux_i (
        .csr_addr(csr_addr),
        .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie),
        .mstatus_sie(mstatus_sie), .mstatus_spie(mstatus_spie),
        .mstatus_spp(mstatus_spp), .mstatus_mpp(mstatus_mpp),
        .mtvec(mtvec), .stvec(stvec), .mscratch(mscratch), .sscratch(sscratch),
        .mepc(mepc), .sepc(sepc), .mcause(mcause), .scause(scause),
        .mtval(mtval), .stval(stval), .medeleg(medeleg),
        .mie(mie), .mideleg(mideleg), .mip(mip),
        .csr_rdata(csr_rdata), .csr_addr_valid(csr_addr_valid)
    );

endmodule

`default_nettype wire

// ==== source/csr_read_mux.sv ====
// Combinational CSR read decode with composed status and interrupt views
// Unknown addresses read zero with csr_addr_valid low
`default_nettype none

module csr_read_mux (
    input  csr_pkg::csr_addr_e        csr_addr,
    input  logic                      mstatus_mie,
    input  logic                      mstatus_mpie,
    input  logic                      mstatus_sie,
    input  logic                      mstatus_spie,
    input  logic                      mstatus_spp,
    input  csr_pkg::priv_e            mstatus_mpp,
    input  logic [csr_pkg::XLEN-1:0]  mtvec,
    input  logic [csr_pkg::XLEN-1:0]  stvec,
    input  logic [csr_pkg::XLEN-1:0]  mscratch,
    input  logic [csr_pkg::XLEN-1:0]  sscratch,
    input  logic [csr_pkg::XLEN-1:0]  mepc,
    input  logic [csr_pkg::XLEN-1:0]  sepc,
    input  logic [csr_pkg::XLEN-1:0]  mcause,
    input  logic [csr_pkg::XLEN-1:0]  scause,
    input  logic [csr_pkg::XLEN-1:0]  mtval,
    input  logic [csr_pkg::XLEN-1:0]  stval,
    input  logic [csr_pkg::XLEN-1:0]  medeleg,
    input  logic [csr_pkg::XLEN-1:0]  mie,
    input  logic [csr_pkg::XLEN-1:0]  mideleg,
    input  logic [csr_pkg::XLEN-1:0]  mip,
    output logic [csr_pkg::XLEN-1:0]  csr_rdata,
    output logic                      csr_addr_valid
);
    import csr_pkg::*;

    logic [XLEN-1:0] mstatus, sstatus;

    // ========================================
    // Status views
    // ========================================
    always_comb begin
        mstatus                 = '0;
        mstatus[MS_SIE]         = mstatus_sie;
        mstatus[MS_MIE]         = mstatus_mie;
        mstatus[MS_SPIE]        = mstatus_spie;
        mstatus[MS_MPIE]        = mstatus_mpie;
        mstatus[MS_SPP]         = mstatus_spp;
        mstatus[MS_MPP+1 -: 2]  = mstatus_mpp;

        // S subset, no M fields visible
        sstatus                 = '0;
        sstatus[MS_SIE]         = mstatus[MS_SIE];
        sstatus[MS_SPIE]        = mstatus[MS_SPIE];
        sstatus[MS_SPP]         = mstatus[MS_SPP];
    end

    // ========================================
    // Address decode
    // ========================================
    always_comb begin
        csr_rdata      = '0;
        csr_addr_valid = 1'b1;  // Cleared by default arm
        case (csr_addr)
            MSTATUS:  csr_rdata = mstatus;
            MISA:     csr_rdata = MISA_VALUE;
            MEDELEG:  csr_rdata = medeleg;
            MIDELEG:  csr_rdata = mideleg;
            MIE:      csr_rdata = mie;
            MTVEC:    csr_rdata = mtvec;
            MSCRATCH: csr_rdata = mscratch;
            MEPC:     csr_rdata = mepc;
            MCAUSE:   csr_rdata = mcause;
            MTVAL:    csr_rdata = mtval;
            MIP:      csr_rdata = mip;
            SSTATUS:  csr_rdata = sstatus;
            SIE:      csr_rdata = mie & S_INT_MASK;
            STVEC:    csr_rdata = stvec;
            SSCRATCH: csr_rdata = sscratch;
            SEPC:     csr_rdata = sepc;
            SCAUSE:   csr_rdata = scause;
            STVAL:    csr_rdata = stval;
            SIP:      csr_rdata = mip & S_INT_MASK;
            default:  csr_addr_valid = 1'b0;  // Unimplemented, illegal instruction
        endcase
    end

endmodule

`default_nettype wire

// ==== trap/trap_ctrl.sv ====
// Privilege level, mstatus fields and the trap CSRs of M and S mode
// Applies CSR writes, then trap entry or MRET/SRET on the same clock edge
`default_nettype none

module trap_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      csr_write,
    input  csr_pkg::csr_addr_e        csr_waddr,
    input  logic [csr_pkg::XLEN-1:0]  csr_wdata,
    input  logic                      trap_taken,
    input  logic [csr_pkg::XLEN-1:0]  trap_cause,
    input  logic [csr_pkg::XLEN-1:0]  trap_pc,
    input  logic [csr_pkg::XLEN-1:0]  trap_val,
    input  logic                      mret_taken,
    input  logic                      sret_taken,
    input  logic [csr_pkg::XLEN-1:0]  mideleg,
    output csr_pkg::priv_e            priv_level,
    output logic                      mstatus_mie,
    output logic                      mstatus_mpie,
    output logic                      mstatus_sie,
    output logic                      mstatus_spie,
    output logic                      mstatus_spp,
    output csr_pkg::priv_e            mstatus_mpp,
    output logic [csr_pkg::XLEN-1:0]  mtvec,
    output logic [csr_pkg::XLEN-1:0]  stvec,
    output logic [csr_pkg::XLEN-1:0]  mscratch,
    output logic [csr_pkg::XLEN-1:0]  sscratch,
    output logic [csr_pkg::XLEN-1:0]  mepc,
    output logic [csr_pkg::XLEN-1:0]  sepc,
    output logic [csr_pkg::XLEN-1:0]  mcause,
    output logic [csr_pkg::XLEN-1:0]  scause,
    output logic [csr_pkg::XLEN-1:0]  mtval,
    output logic [csr_pkg::XLEN-1:0]  stval,
    output logic [csr_pkg::XLEN-1:0]  medeleg,
    output logic [csr_pkg::XLEN-1:0]  trap_vector,
    output logic [csr_pkg::XLEN-1:0]  trap_return_pc,
    output logic                      trap_to_s_mode
);
    import csr_pkg::*;

    logic [4:0] trap_code;
    logic       trap_delegated;

    // ========================================
    // Delegation and vector select
    // ========================================
    assign trap_code      = trap_cause[4:0];
    assign trap_delegated = trap_cause[XLEN-1] ? mideleg[trap_code] : medeleg[trap_code];
    assign trap_to_s_mode = (priv_level != PRIV_M) && trap_delegated;  // Never delegate from M
    assign trap_vector    = trap_to_s_mode ? stvec : mtvec;
    assign trap_return_pc = sret_taken ? sepc : mepc;

    // ========================================
    // Writes, trap entry, returns
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            priv_level   <= PRIV_M;  // Boot in M
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_sie  <= 1'b0;
            mstatus_spie <= 1'b0;
            mstatus_spp  <= 1'b0;
            mstatus_mpp  <= PRIV_M;
            mtvec        <= '0;
            stvec        <= '0;
            mscratch     <= '0;
            sscratch     <= '0;
            mepc         <= '0;
            sepc         <= '0;
            mcause       <= '0;
            scause       <= '0;
            mtval        <= '0;
            stval        <= '0;
            medeleg      <= '0;
        end else begin
            // CSR write first, trap below overrides shared fields
            if (csr_write) begin
                case (csr_waddr)
                    MSTATUS: begin
                        mstatus_mie  <= csr_wdata[MS_MIE];
                        mstatus_mpie <= csr_wdata[MS_MPIE];
                        mstatus_sie  <= csr_wdata[MS_SIE];
                        mstatus_spie <= csr_wdata[MS_SPIE];
                        mstatus_spp  <= csr_wdata[MS_SPP];
                        // WARL, reserved level 2 keeps the old MPP
                        if (csr_wdata[MS_MPP+1 -: 2] != 2'b10) begin
                            mstatus_mpp <= priv_e'(csr_wdata[MS_MPP+1 -: 2]);
                        end
                    end
                    SSTATUS: begin  // S view, M fields untouched
                        mstatus_sie  <= csr_wdata[MS_SIE];
                        mstatus_spie <= csr_wdata[MS_SPIE];
                        mstatus_spp  <= csr_wdata[MS_SPP];
                    end
                    MTVEC:    mtvec    <= {csr_wdata[XLEN-1:2], 2'b00};  // Direct mode only
                    STVEC:    stvec    <= {csr_wdata[XLEN-1:2], 2'b00};
                    MSCRATCH: mscratch <= csr_wdata;
                    SSCRATCH: sscratch <= csr_wdata;
                    MEPC:     mepc     <= {csr_wdata[XLEN-1:1], 1'b0};   // IALIGN 16
                    SEPC:     sepc     <= {csr_wdata[XLEN-1:1], 1'b0};
                    MCAUSE:   mcause   <= csr_wdata;
                    SCAUSE:   scause   <= csr_wdata;
                    MTVAL:    mtval    <= csr_wdata;
                    STVAL:    stval    <= csr_wdata;
                    MEDELEG:  medeleg  <= csr_wdata & MEDELEG_MASK;
                    default: ;  // Owned by irq_ctrl or read-only
                endcase
            end

            if (trap_taken) begin
                if (trap_to_s_mode) begin
                    sepc         <= trap_pc;
                    scause       <= trap_cause;
                    stval        <= trap_val;
                    mstatus_spie <= mstatus_sie;
                    mstatus_sie  <= 1'b0;
                    mstatus_spp  <= (priv_level == PRIV_S);  // Only U or S here
                    priv_level   <= PRIV_S;
                end else begin
                    mepc         <= trap_pc;
                    mcause       <= trap_cause;
                    mtval        <= trap_val;
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                    mstatus_mpp  <= priv_level;
                    priv_level   <= PRIV_M;
                end
            end else if (mret_taken) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
                priv_level   <= mstatus_mpp;
                mstatus_mpp  <= PRIV_U;  // Least privileged supported mode
            end else if (sret_taken) begin
                mstatus_sie  <= mstatus_spie;
                mstatus_spie <= 1'b1;
                priv_level   <= mstatus_spp ? PRIV_S : PRIV_U;
                mstatus_spp  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== irq/irq_ctrl.sv ====
// Interrupt enable, delegation and software-pending bits of one hart
// Arbitrates pending interrupts by privilege and fixed priority
`default_nettype none

module irq_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      csr_write,
    input  csr_pkg::csr_addr_e        csr_waddr,
    input  logic [csr_pkg::XLEN-1:0]  csr_wdata,
    input  logic                      timer_irq,
    input  logic                      external_irq,
    input  logic                      software_irq,
    input  csr_pkg::priv_e            priv_level,
    input  logic                      mstatus_mie,
    input  logic                      mstatus_sie,
    output logic [csr_pkg::XLEN-1:0]  mie,
    output logic [csr_pkg::XLEN-1:0]  mideleg,
    output logic [csr_pkg::XLEN-1:0]  mip,
    output logic                      interrupt_pending,
    output logic [csr_pkg::XLEN-1:0]  interrupt_cause
);
    import csr_pkg::*;

    logic            seip_sw, stip_sw, ssip_sw;  // Software-owned pending bits
    logic [XLEN-1:0] m_ints, s_ints;
    logic            m_take, s_take;

    // Fixed priority MEI > MSI > MTI > SEI > SSI > STI
    function automatic logic [XLEN-1:0] pick_cause(input logic [XLEN-1:0] pend);
        logic [XLEN-1:0] cause;
        cause = '0;
        if (pend[IRQ_MEI])      cause = IRQ_MEI;
        else if (pend[IRQ_MSI]) cause = IRQ_MSI;
        else if (pend[IRQ_MTI]) cause = IRQ_MTI;
        else if (pend[IRQ_SEI]) cause = IRQ_SEI;
        else if (pend[IRQ_SSI]) cause = IRQ_SSI;
        else if (pend[IRQ_STI]) cause = IRQ_STI;
        if (pend != '0) cause[XLEN-1] = 1'b1;  // Interrupt flag
        return cause;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mie     <= '0;
            mideleg <= '0;
            seip_sw <= 1'b0;
            stip_sw <= 1'b0;
            ssip_sw <= 1'b0;
        end else if (csr_write) begin
            case (csr_waddr)
                MIE:     mie     <= csr_wdata & MIE_MASK;
                SIE:     mie     <= (mie & ~S_INT_MASK) | (csr_wdata & S_INT_MASK);
                MIDELEG: mideleg <= csr_wdata & S_INT_MASK;  // Only S interrupts
                MIP: begin
                    seip_sw <= csr_wdata[IRQ_SEI];
                    stip_sw <= csr_wdata[IRQ_STI];
                    ssip_sw <= csr_wdata[IRQ_SSI];
                end
                SIP:     ssip_sw <= csr_wdata[IRQ_SSI];  // SSIP only
                default: ;
            endcase
        end
    end

    // Pending view, lines for M and software bits for S
    always_comb begin
        mip          = '0;
        mip[IRQ_MEI] = external_irq;
        mip[IRQ_MTI] = timer_irq;
        mip[IRQ_MSI] = software_irq;
        mip[IRQ_SEI] = seip_sw;
        mip[IRQ_STI] = stip_sw;
        mip[IRQ_SSI] = ssip_sw;
    end

    assign m_ints = mip & mie & ~mideleg;
    assign s_ints = mip & mie & mideleg;
    assign m_take = (m_ints != '0) && ((priv_level != PRIV_M) || mstatus_mie);
    assign s_take = (s_ints != '0) &&
                    ((priv_level == PRIV_U) || ((priv_level == PRIV_S) && mstatus_sie));

    assign interrupt_pending = m_take || s_take;
    assign interrupt_cause   = m_take ? pick_cause(m_ints) : pick_cause(s_ints);  // M first

endmodule

`default_nettype wire

// ==== common/csr_pkg.sv ====
// Shared types and constants for the RISC-V trap and privilege CSR block
// Imported by every RTL module and by the bound assertion module
`default_nettype none

package csr_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int XLEN       = 32;   // RV32 only
    localparam int CSR_ADDR_W = 12;

    // Privilege levels, encoding 2 is reserved
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_e;

    // Implemented CSR addresses
    typedef enum logic [CSR_ADDR_W-1:0] {
        SSTATUS  = 12'h100,
        SIE      = 12'h104,
        STVEC    = 12'h105,
        SSCRATCH = 12'h140,
        SEPC     = 12'h141,
        SCAUSE   = 12'h142,
        STVAL    = 12'h143,
        SIP      = 12'h144,
        MSTATUS  = 12'h300,
        MISA     = 12'h301,
        MEDELEG  = 12'h302,
        MIDELEG  = 12'h303,
        MIE      = 12'h304,
        MTVEC    = 12'h305,
        MSCRATCH = 12'h340,
        MEPC     = 12'h341,
        MCAUSE   = 12'h342,
        MTVAL    = 12'h343,
        MIP      = 12'h344
    } csr_addr_e;

    // ========================================
    // Field masks
    // ========================================
    localparam logic [XLEN-1:0] S_INT_MASK   = 32'h0000_0222;  // SEI, STI, SSI
    localparam logic [XLEN-1:0] MIE_MASK     = 32'h0000_0AAA;
    localparam logic [XLEN-1:0] MEDELEG_MASK = 32'h0000_B3FF;

    // MXL=1 (RV32) with S, M, I and A extensions
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4004_1101;

    // Interrupt bit positions in mip/mie, also the interrupt cause codes
    localparam int IRQ_MEI = 11;
    localparam int IRQ_SEI = 9;
    localparam int IRQ_MTI = 7;
    localparam int IRQ_STI = 5;
    localparam int IRQ_MSI = 3;
    localparam int IRQ_SSI = 1;

    // mstatus bit positions
    localparam int MS_SIE  = 1;
    localparam int MS_MIE  = 3;
    localparam int MS_SPIE = 5;
    localparam int MS_MPIE = 7;
    localparam int MS_SPP  = 8;
    localparam int MS_MPP  = 11;  // Low bit of MPP[12:11]

endpackage

`default_nettype wire
